/* design/isaPkg.sv */
package isaPkg;

    // Machine word and field widths
    localparam int XLEN        = 32;
    localparam int RegIdxWidth = 5;
    localparam int OpcodeWidth = 7;
    localparam int Funct3Width = 3;
    localparam int Funct7Width = 7;

    typedef logic [31:0] instWord;

    // Major opcodes of the supported subset
    localparam logic [OpcodeWidth-1:0] OpReg   = 7'b0110011;
    localparam logic [OpcodeWidth-1:0] OpImm   = 7'b0010011;
    localparam logic [OpcodeWidth-1:0] OpLui   = 7'b0110111;
    localparam logic [OpcodeWidth-1:0] OpStore = 7'b0100011;

    // funct3 for arithmetic, logic and shift operations
    localparam logic [Funct3Width-1:0] F3Add  = 3'b000;
    localparam logic [Funct3Width-1:0] F3Sll  = 3'b001;
    localparam logic [Funct3Width-1:0] F3Slt  = 3'b010;
    localparam logic [Funct3Width-1:0] F3Sltu = 3'b011;
    localparam logic [Funct3Width-1:0] F3Xor  = 3'b100;
    localparam logic [Funct3Width-1:0] F3Srl  = 3'b101;
    localparam logic [Funct3Width-1:0] F3Or   = 3'b110;
    localparam logic [Funct3Width-1:0] F3And  = 3'b111;

    // Store width, only words are supported
    localparam logic [Funct3Width-1:0] F3Sw   = 3'b010;

    // Selects SUB over ADD and SRA over SRL
    localparam logic [Funct7Width-1:0] F7Alt  = 7'b0100000;

endpackage

/* design/corePkg.sv */
package corePkg;

    typedef logic [isaPkg::RegIdxWidth-1:0] regIdx;

    // Operations of the execute stage ALU
    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluSll,
        AluSlt,
        AluSltu,
        AluXor,
        AluSrl,
        AluSra,
        AluOr,
        AluAnd,
        AluPassB
    } aluOpT;

    // Where an execute operand comes from
    typedef enum logic [1:0] {
        FwdReg,
        FwdMem,
        FwdWb
    } fwdSelT;

endpackage

/* design/programCounter.sv */
`timescale 1ns/1ps

module programCounter #(
    parameter logic [isaPkg::XLEN-1:0] ResetAddr = '0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    hold,
    output logic [isaPkg::XLEN-1:0] pc,
    output logic                    fetchValid
);
    import isaPkg::*;

    localparam logic [XLEN-1:0] WordStep = XLEN'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= ResetAddr;
            fetchValid <= 1'b0;
        end else if (!hold) begin
            pc <= pc + WordStep;
            // Memory output is meaningful only after the first capture
            fetchValid <= 1'b1;
        end
    end

endmodule

/* design/instDecoder.sv */
`timescale 1ns/1ps

module instDecoder (
    input  isaPkg::instWord         inst,
    input  logic                    valid,
    output corePkg::regIdx          rs1,
    output corePkg::regIdx          rs2,
    output corePkg::regIdx          rd,
    output logic [isaPkg::XLEN-1:0] imm,
    output corePkg::aluOpT          aluOp,
    output logic                    useImm,
    output logic                    regWrite,
    output logic                    isStore
);
    import isaPkg::*;
    import corePkg::*;

    logic [OpcodeWidth-1:0] opcode;
    logic [Funct3Width-1:0] funct3;
    logic [Funct7Width-1:0] funct7;
    logic                   isShift;
    logic                   altSel;
    logic                   known;
    logic                   storeOp;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign rs1     = inst[19:15];
    assign rs2     = inst[24:20];
    assign rd      = inst[11:7];
    assign isShift = (funct3 == F3Sll) || (funct3 == F3Srl);
    assign altSel  = (funct7 == F7Alt);

    always_comb begin
        imm     = '0;
        useImm  = 1'b0;
        known   = 1'b0;
        storeOp = 1'b0;
        aluOp   = AluAdd;
        case (funct3)
            F3Add:  aluOp = (opcode == OpReg && altSel) ? AluSub : AluAdd;
            F3Sll:  aluOp = AluSll;
            F3Slt:  aluOp = AluSlt;
            F3Sltu: aluOp = AluSltu;
            F3Xor:  aluOp = AluXor;
            F3Srl:  aluOp = altSel ? AluSra : AluSrl;
            F3Or:   aluOp = AluOr;
            default: aluOp = AluAnd;
        endcase
        case (opcode)
            OpReg: begin
                // funct7 may only be zero, or the alternate form of ADD/SRL
                known = (funct7 == '0) || (altSel && (funct3 == F3Add || funct3 == F3Srl));
            end
            OpImm: begin
                useImm = 1'b1;
                if (isShift) begin
                    // Shift amount only, the upper field picks the variant
                    imm   = XLEN'(inst[24:20]);
                    known = (funct7 == '0) || (altSel && funct3 == F3Srl);
                end else begin
                    imm   = {{20{inst[31]}}, inst[31:20]};
                    known = 1'b1;
                end
            end
            OpLui: begin
                imm    = {inst[31:12], 12'b0};
                useImm = 1'b1;
                aluOp  = AluPassB;
                known  = 1'b1;
            end
            OpStore: begin
                imm     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                useImm  = 1'b1;
                aluOp   = AluAdd;
                storeOp = (funct3 == F3Sw);
            end
            default: known = 1'b0;
        endcase
    end

    // Anything else travels down the pipe as a bubble
    assign regWrite = valid && known && (rd != '0);
    assign isStore  = valid && storeOp;

endmodule

/* design/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    writeEn,
    input  corePkg::regIdx          writeIdx,
    input  corePkg::regIdx          readIdx1,
    input  corePkg::regIdx          readIdx2,
    input  logic [isaPkg::XLEN-1:0] writeData,
    output logic [isaPkg::XLEN-1:0] readData1,
    output logic [isaPkg::XLEN-1:0] readData2
);
    import isaPkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeIdx != '0) begin
            regs[writeIdx] <= writeData;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign readData1 = (readIdx1 == '0) ? '0 :
                       (writeEn && writeIdx == readIdx1) ? writeData :
                       regs[readIdx1];

    assign readData2 = (readIdx2 == '0) ? '0 :
                       (writeEn && writeIdx == readIdx2) ? writeData :
                       regs[readIdx2];

endmodule

/* design/executeUnit.sv */
`timescale 1ns/1ps

module executeUnit (
    input  corePkg::regIdx          rs1,
    input  corePkg::regIdx          rs2,
    input  logic [isaPkg::XLEN-1:0] rs1Data,
    input  logic [isaPkg::XLEN-1:0] rs2Data,
    input  logic [isaPkg::XLEN-1:0] imm,
    input  corePkg::aluOpT          aluOp,
    input  logic                    useImm,
    input  corePkg::regIdx          memRd,
    input  corePkg::regIdx          wbRd,
    input  logic                    memRegWrite,
    input  logic                    wbRegWrite,
    input  logic [isaPkg::XLEN-1:0] memResult,
    input  logic [isaPkg::XLEN-1:0] wbResult,
    output logic [isaPkg::XLEN-1:0] result,
    output logic [isaPkg::XLEN-1:0] storeData
);
    import isaPkg::*;
    import corePkg::*;

    fwdSelT          selA;
    fwdSelT          selB;
    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] srcB;
    logic [XLEN-1:0] opB;
    logic [4:0]      shamt;

    // Nearer stage wins
    assign selA = (rs1 != '0 && memRegWrite && memRd == rs1) ? FwdMem :
                  (rs1 != '0 && wbRegWrite && wbRd == rs1)   ? FwdWb  : FwdReg;
    assign selB = (rs2 != '0 && memRegWrite && memRd == rs2) ? FwdMem :
                  (rs2 != '0 && wbRegWrite && wbRd == rs2)   ? FwdWb  : FwdReg;

    always_comb begin
        case (selA)
            FwdMem:  srcA = memResult;
            FwdWb:   srcA = wbResult;
            default: srcA = rs1Data;
        endcase
        case (selB)
            FwdMem:  srcB = memResult;
            FwdWb:   srcB = wbResult;
            default: srcB = rs2Data;
        endcase
    end

    assign opB       = useImm ? imm : srcB;
    assign shamt     = opB[4:0];
    assign storeData = srcB;

    always_comb begin
        case (aluOp)
            AluAdd:   result = srcA + opB;
            AluSub:   result = srcA - opB;
            AluSll:   result = srcA << shamt;
            AluSlt:   result = XLEN'($signed(srcA) < $signed(opB));
            AluSltu:  result = XLEN'(srcA < opB);
            AluXor:   result = srcA ^ opB;
            AluSrl:   result = srcA >> shamt;
            AluSra:   result = $signed(srcA) >>> shamt;
            AluOr:    result = srcA | opB;
            AluAnd:   result = srcA & opB;
            default:  result = opB;
        endcase
    end

endmodule

/* design/rvCore.sv */
`timescale 1ns/1ps

module rvCore #(
    parameter logic [isaPkg::XLEN-1:0] ResetAddr = '0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instWait,
    input  isaPkg::instWord         instData,
    output logic [isaPkg::XLEN-1:0] instAddr,
    output logic                    dataWrite,
    output logic [isaPkg::XLEN-1:0] dataAddr,
    output logic [isaPkg::XLEN-1:0] dataOut
);
    import isaPkg::*;
    import corePkg::*;

    logic            fetchValid;
    instWord         ifInst;
    logic            ifValid;
    regIdx           idRs1, idRs2, idRd;
    logic [XLEN-1:0] idImm, idRs1Data, idRs2Data;
    aluOpT           idAluOp;
    logic            idUseImm, idRegWrite, idStore;
    regIdx           exRs1, exRs2, exRd;
    logic [XLEN-1:0] exRs1Data, exRs2Data, exImm, exResult, exStoreData;
    aluOpT           exAluOp;
    logic            exUseImm, exRegWrite, exStore;
    regIdx           memRd;
    logic [XLEN-1:0] memResult, memStoreData;
    logic            memRegWrite, memStore;
    regIdx           wbRd;
    logic [XLEN-1:0] wbResult;
    logic            wbRegWrite;

    programCounter #(.ResetAddr(ResetAddr)) pcUnit (
        .clk(clk), .rst(rst), .hold(instWait), .pc(instAddr), .fetchValid(fetchValid)
    );

    instDecoder decoder (
        .inst(ifInst), .valid(ifValid), .rs1(idRs1), .rs2(idRs2), .rd(idRd), .imm(idImm),
        .aluOp(idAluOp), .useImm(idUseImm), .regWrite(idRegWrite), .isStore(idStore)
    );

    // Write is frozen with the rest of the core
    registerFile regFile (
        .clk(clk), .rst(rst), .writeEn(wbRegWrite && !instWait), .writeIdx(wbRd),
        .readIdx1(idRs1), .readIdx2(idRs2), .writeData(wbResult),
        .readData1(idRs1Data), .readData2(idRs2Data)
    );

    executeUnit execute (
        .rs1(exRs1), .rs2(exRs2), .rs1Data(exRs1Data), .rs2Data(exRs2Data), .imm(exImm),
        .aluOp(exAluOp), .useImm(exUseImm), .memRd(memRd), .wbRd(wbRd),
        .memRegWrite(memRegWrite), .wbRegWrite(wbRegWrite), .memResult(memResult),
        .wbResult(wbResult), .result(exResult), .storeData(exStoreData)
    );

    // Pipeline control bits
    always_ff @(posedge clk) begin
        if (rst) begin
            ifValid     <= 1'b0;
            exRegWrite  <= 1'b0;
            exStore     <= 1'b0;
            memRegWrite <= 1'b0;
            memStore    <= 1'b0;
            wbRegWrite  <= 1'b0;
        end else if (!instWait) begin
            ifValid     <= fetchValid;
            exRegWrite  <= idRegWrite;
            exStore     <= idStore;
            memRegWrite <= exRegWrite;
            memStore    <= exStore;
            wbRegWrite  <= memRegWrite;
        end
    end

    // Pipeline payload
    always_ff @(posedge clk) begin
        if (!instWait) begin
            ifInst       <= instData;
            exRs1        <= idRs1;
            exRs2        <= idRs2;
            exRd         <= idRd;
            exRs1Data    <= idRs1Data;
            exRs2Data    <= idRs2Data;
            exImm        <= idImm;
            exAluOp      <= idAluOp;
            exUseImm     <= idUseImm;
            memRd        <= exRd;
            memResult    <= exResult;
            memStoreData <= exStoreData;
            wbRd         <= memRd;
            wbResult     <= memResult;
        end
    end

    // One store pulse per instruction, suppressed while frozen
    assign dataWrite = memStore && !instWait;
    assign dataAddr  = memResult;
    assign dataOut   = memStoreData;

endmodule

/* tests/rvCore_assert.sv */
`timescale 1ns/1ps

module rvCoreAssert (
    input logic                    clk,
    input logic                    rst,
    input logic                    instWait,
    input logic [isaPkg::XLEN-1:0] instAddr,
    input logic                    dataWrite
);
    import isaPkg::*;

    int errorCount = 0;

    quietAfterReset: assert property (@(posedge clk) rst |=> !dataWrite)
        else begin
            $error("dataWrite high in the cycle after reset");
            errorCount++;
        end

    noStoreWhileWait: assert property (@(posedge clk) dataWrite |-> !instWait)
        else begin
            $error("dataWrite high while instWait is high");
            errorCount++;
        end

    // Fetch address holds on a wait and steps one word otherwise
    addrHolds: assert property (@(posedge clk) (!rst && instWait) |=> $stable(instAddr))
        else begin
            $error("instAddr moved during a wait");
            errorCount++;
        end

    addrSteps: assert property (@(posedge clk)
        (!rst && !instWait) |=> instAddr == $past(instAddr) + XLEN'(4))
        else begin
            $error("instAddr did not advance by one word");
            errorCount++;
        end

endmodule

bind rvCore rvCoreAssert assertions (
    .clk(clk), .rst(rst), .instWait(instWait), .instAddr(instAddr), .dataWrite(dataWrite)
);

/* tests/rvCoreTb.sv */
`timescale 1ns/1ps

module rvCoreTb;
    import isaPkg::*;

    localparam int              Depth     = 256;
    localparam int              ProgLen   = 200;
    localparam int              MaxCycles = 4000;
    localparam logic [XLEN-1:0] StallFrom = 32'h100;
    localparam logic [XLEN-1:0] EndAddr   = (Depth - 8) * 4;

    logic            clk      = 1'b0;
    logic            rst      = 1'b1;
    logic            instWait = 1'b0;
    instWord         instData = '0;
    logic [XLEN-1:0] instAddr;
    logic            dataWrite;
    logic [XLEN-1:0] dataAddr;
    logic [XLEN-1:0] dataOut;

    integer          seed = 36404;
    instWord         imem [0:Depth-1];
    logic [XLEN-1:0] modelRegs [0:31] = '{default: '0};
    logic [63:0]     expStores [0:Depth-1];
    logic            stallPlan [0:MaxCycles-1];
    int              expCount  = 0;
    int              storeIdx  = 0;
    int              advCount  = 0;
    int              edgeCount = 0;
    int              cycles;
    int              fetchQ [$];

    rvCore #(.ResetAddr(32'h0)) dut (
        .clk(clk), .rst(rst), .instWait(instWait), .instData(instData), .instAddr(instAddr),
        .dataWrite(dataWrite), .dataAddr(dataAddr), .dataOut(dataOut)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    task automatic stopOnError();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, name, actual, expected);
            stopOnError();
        end
    endtask

    // Reference semantics of the RV32I integer operations
    function automatic logic [31:0] aluModel(logic [2:0] f3, logic alt, logic [31:0] a,
                                             logic [31:0] b);
        case (f3)
            F3Add:   return alt ? a - b : a + b;
            F3Sll:   return a << b[4:0];
            F3Slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3Sltu:  return (a < b) ? 32'd1 : 32'd0;
            F3Xor:   return a ^ b;
            F3Srl: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            F3Or:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Executes one instruction in program order
    task automatic runModel(input instWord w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] iImm;
        a    = modelRegs[w[19:15]];
        b    = modelRegs[w[24:20]];
        iImm = {{20{w[31]}}, w[31:20]};
        case (w[6:0])
            OpLui: begin
                if (w[11:7] != 5'd0) modelRegs[w[11:7]] = {w[31:12], 12'd0};
            end
            OpReg: begin
                if (w[11:7] != 5'd0) modelRegs[w[11:7]] = aluModel(w[14:12], w[30], a, b);
            end
            OpImm: begin
                if (w[11:7] != 5'd0) begin
                    modelRegs[w[11:7]] = aluModel(w[14:12], w[30] && w[14:12] == F3Srl, a, iImm);
                end
            end
            OpStore: begin
                expStores[expCount] = {a + {{20{w[31]}}, w[31:25], w[11:7]}, b};
                expCount++;
            end
            default: ;
        endcase
    endtask

    // Random program over x0..x7, so dependencies are frequent
    task automatic fillProgram();
        logic [31:0] rnd;
        logic [31:0] sel;
        logic [2:0]  f3;
        logic [6:0]  f7;
        for (int i = 0; i < Depth; i++) begin
            rnd = $random(seed);
            sel = {$random(seed)} % 24;
            f3  = rnd[14:12];
            f7  = ((f3 == F3Add || f3 == F3Srl) && rnd[30]) ? F7Alt : 7'd0;
            if (i >= ProgLen) begin
                imem[i] = {i[11:0], 5'd0, F3Add, 5'd0, OpImm};
            end else if (sel < 4) begin
                imem[i] = {rnd[31:25], 2'b0, rnd[22:20], 2'b0, rnd[17:15], F3Sw, rnd[11:7],
                           OpStore};
            end else if (sel == 4) begin
                // Load opcode, not part of the kept subset
                imem[i] = {rnd[31:7], 7'b0000011};
            end else if (sel == 5) begin
                imem[i] = {rnd[31:12], 2'b0, rnd[9:7], OpLui};
            end else if (sel < 15) begin
                imem[i] = {f7, 2'b0, rnd[22:20], 2'b0, rnd[17:15], f3, 2'b0, rnd[9:7], OpReg};
            end else if (f3 == F3Sll || f3 == F3Srl) begin
                imem[i] = {f7, rnd[24:20], 2'b0, rnd[17:15], f3, 2'b0, rnd[9:7], OpImm};
            end else begin
                imem[i] = {rnd[31:20], 2'b0, rnd[17:15], f3, 2'b0, rnd[9:7], OpImm};
            end
        end
    endtask

    // Instruction memory, wait generator and store monitor
    always @(posedge clk) begin
        if (!instWait) begin
            instData <= imem[instAddr[9:2]];
        end
        if (!rst) begin
            instWait <= (instAddr >= StallFrom) && stallPlan[edgeCount % MaxCycles];
            edgeCount++;
            if (dataWrite) begin
                if (storeIdx >= expCount || fetchQ.size() == 0) begin
                    $display("The core wrote a store that the program does not contain");
                    stopOnError();
                end
                checkValue("dataAddr", dataAddr, expStores[storeIdx][63:32]);
                checkValue("dataOut", dataOut, expStores[storeIdx][31:0]);
                // Counted in edges without a wait
                checkValue("store latency", advCount - fetchQ.pop_front(), 32'd4);
                storeIdx++;
            end
            if (!instWait) begin
                if (imem[instAddr[9:2]][6:0] == OpStore) fetchQ.push_back(advCount);
                advCount++;
            end
            checkValue("assertion errors", dut.assertions.errorCount, 32'd0);
        end
    end

    initial begin
        fillProgram();
        for (int i = 0; i < Depth; i++) begin
            runModel(imem[i]);
        end
        for (int c = 0; c < MaxCycles; c++) begin
            stallPlan[c] = ({$random(seed)} % 10) < 3;
        end
        repeat (2) @(posedge clk);
        checkValue("instAddr", instAddr, 32'h0);
        rst <= 1'b0;
        cycles = 0;
        while (instAddr < EndAddr && cycles < MaxCycles) begin
            @(posedge clk);
            cycles++;
        end
        if (instAddr < EndAddr) begin
            $display("Timeout: the core did not fetch to the end of the program");
            stopOnError();
        end
        if (storeIdx == expCount) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Only %0d of %0d expected stores were written", storeIdx, expCount);
            stopOnError();
        end
    end

endmodule

/* rvCore.f */
design/isaPkg.sv
design/corePkg.sv
design/programCounter.sv
design/instDecoder.sv
design/registerFile.sv
design/executeUnit.sv
design/rvCore.sv
tests/rvCore_assert.sv
tests/rvCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rvCoreTb -f rvCore.f -o rvCoreSim

output=$(./obj_dir/rvCoreSim 2>&1) || true
echo "$output"

if grep -qx "STATUS: PASS" <<< "$output"; then
    exit 0
fi
exit 1
